// ==== hdl/memCachePkg.sv ====
package memCachePkg;

	// widths of the physical address path
	localparam int ADDR_BITS = 32;
	localparam int WORD_BITS = 32;
	localparam int LINE_BITS = 128;

	// direct-mapped geometry, 16 lines of 16 bytes
	localparam int LINE_COUNT = 16;
	localparam int INDEX_BITS = 4;
	localparam int OFFSET_BITS = 4;
	localparam int TAG_BITS = ADDR_BITS - INDEX_BITS - OFFSET_BITS;
	localparam int WORD_SEL_BITS = OFFSET_BITS - 2;	// word within a line

	typedef logic [ADDR_BITS-1:0] addrT;	// byte address
	typedef logic [WORD_BITS-1:0] wordT;
	typedef logic [LINE_BITS-1:0] lineT;
	typedef logic [TAG_BITS-1:0] tagT;
	typedef logic [INDEX_BITS-1:0] indexT;
	typedef logic [WORD_SEL_BITS-1:0] wordSelT;

	typedef logic [1:0] okT;
	typedef logic [1:0] opmT;
	typedef logic [15:0] excT;	// bit 15 set means a live exception

	// OK codes returned by the line-fill port
	localparam okT OK_READY = 2'b00;	// idle, may start
	localparam okT OK_OK = 2'b01;	// done, one cycle only
	localparam okT OK_HOLD = 2'b10;	// busy, keep request steady
	localparam okT OK_FAULT = 2'b11;	// bus error, one cycle only

	// operation modes on the line-fill port
	localparam opmT OPM_NONE = 2'b00;
	localparam opmT OPM_LOAD_LINE = 2'b01;
	localparam opmT OPM_STORE_WORD = 2'b10;

	// exception codes reported by the arbiter
	localparam excT EXC_FETCH_FAULT = 16'h8001;
	localparam excT EXC_DATA_FAULT = 16'h8002;

	typedef enum logic [1:0]
	{
		IDLE,	// lookup, may accept a strobe
		FILL,	// line load outstanding
		WRITE,	// write-through store outstanding
		DONE	// response cycle after a port access
	} cacheStateT;

	// pick one 32-bit word out of a cache line
	function automatic wordT lineWord(lineT line, wordSelT sel);
		return line[sel*WORD_BITS +: WORD_BITS];
	endfunction

endpackage

// ==== hdl/lineFillIf.sv ====
`timescale 1ns/1ps

interface lineFillIf;

	import memCachePkg::*;

	addrT addr;	// line address, or word address for stores
	opmT opm;	// held non-zero for the whole request
	wordT wData;	// store data
	lineT rData;	// returned line
	okT ok;

	modport cache
	(
		output addr, opm, wData,
		input rData, ok
	);

	modport arbiter
	(
		input addr, opm, wData,
		output rData, ok
	);

endinterface

// ==== hdl/instCache.sv ====
`timescale 1ns/1ps

module instCache
(
	input logic clock,
	input logic arstN,
	input logic fetchReq,
	input memCachePkg::addrT fetchPc,
	output logic fetchValid,
	output memCachePkg::wordT fetchInstr,
	output logic fetchErr,
	lineFillIf.cache fill
);

	import memCachePkg::*;

	cacheStateT state;
	tagT tagMem [LINE_COUNT];
	lineT lineMem [LINE_COUNT];
	logic [LINE_COUNT-1:0] lineValid;

	addrT missAddr;	// pc of the fetch being filled
	tagT reqTag;
	indexT reqIdx;
	wordSelT reqSel;
	tagT missTag;
	indexT missIdx;
	wordSelT missSel;
	logic ready;
	logic hit;
	logic fillDone;

	assign reqTag = fetchPc[ADDR_BITS-1 -: TAG_BITS];
	assign reqIdx = fetchPc[OFFSET_BITS +: INDEX_BITS];
	assign reqSel = fetchPc[2 +: WORD_SEL_BITS];
	assign missTag = missAddr[ADDR_BITS-1 -: TAG_BITS];
	assign missIdx = missAddr[OFFSET_BITS +: INDEX_BITS];
	assign missSel = missAddr[2 +: WORD_SEL_BITS];

	assign ready = (state == IDLE) || (state == DONE);
	assign hit = lineValid[reqIdx] && (tagMem[reqIdx] == reqTag);
	assign fillDone = (state == FILL) && ((fill.ok == OK_OK) || (fill.ok == OK_FAULT));

	// request held steady straight from the state register
	assign fill.opm = (state == FILL) ? OPM_LOAD_LINE : OPM_NONE;
	assign fill.addr = {missAddr[ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
	assign fill.wData = '0;	// fetch side never stores

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= IDLE;
			lineValid <= '0;
			fetchValid <= 1'b0;
		end
		else
		begin
			fetchValid <= 1'b0;
			case (state)
				IDLE, DONE:
				begin
					state <= IDLE;
					if (fetchReq && hit)
						fetchValid <= 1'b1;	// hit answers next cycle
					else if (fetchReq)
						state <= FILL;
				end
				FILL:
				begin
					if (fillDone)
					begin
						fetchValid <= 1'b1;
						state <= DONE;
						if (fill.ok == OK_OK)
							lineValid[missIdx] <= 1'b1;
					end
				end
				default:
					state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (ready && fetchReq)
		begin
			missAddr <= fetchPc;
			fetchInstr <= lineWord(lineMem[reqIdx], reqSel);
			fetchErr <= 1'b0;
		end
		if (fillDone)
		begin
			fetchInstr <= lineWord(fill.rData, missSel);	// forward from the fill
			fetchErr <= (fill.ok == OK_FAULT);
		end
		if (fillDone && (fill.ok == OK_OK))
		begin
			tagMem[missIdx] <= missTag;
			lineMem[missIdx] <= fill.rData;
		end
	end

	// held request on the external port must not move while memory stalls
	assert property (@(posedge clock) disable iff (!arstN)
		(fill.ok == OK_HOLD) |=> $stable(fill.opm));

endmodule

// ==== hdl/dataCache.sv ====
`timescale 1ns/1ps

module dataCache
(
	input logic clock,
	input logic arstN,
	input logic dataReq,
	input logic dataWrite,
	input memCachePkg::addrT dataAddr,
	input memCachePkg::wordT dataWData,
	output logic dataValid,
	output logic dataErr,
	output memCachePkg::wordT dataRData,
	lineFillIf.cache fill
);

	import memCachePkg::*;

	cacheStateT state;
	tagT tagMem [LINE_COUNT];
	lineT lineMem [LINE_COUNT];
	logic [LINE_COUNT-1:0] lineValid;

	addrT missAddr;	// address of the access on the port
	wordT storeData;
	tagT reqTag;
	indexT reqIdx;
	wordSelT reqSel;
	tagT missTag;
	indexT missIdx;
	wordSelT missSel;
	logic access;
	logic ready;
	logic hit;
	logic portDone;

	assign reqTag = dataAddr[ADDR_BITS-1 -: TAG_BITS];
	assign reqIdx = dataAddr[OFFSET_BITS +: INDEX_BITS];
	assign reqSel = dataAddr[2 +: WORD_SEL_BITS];
	assign missTag = missAddr[ADDR_BITS-1 -: TAG_BITS];
	assign missIdx = missAddr[OFFSET_BITS +: INDEX_BITS];
	assign missSel = missAddr[2 +: WORD_SEL_BITS];

	// a store strobe counts as an access on its own
	assign access = dataReq || dataWrite;
	assign ready = (state == IDLE) || (state == DONE);
	assign hit = lineValid[reqIdx] && (tagMem[reqIdx] == reqTag);
	assign portDone = ((state == FILL) || (state == WRITE)) &&
		((fill.ok == OK_OK) || (fill.ok == OK_FAULT));

	always_comb
	begin
		fill.opm = OPM_NONE;
		fill.addr = {missAddr[ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
		fill.wData = storeData;
		if (state == FILL)
			fill.opm = OPM_LOAD_LINE;
		else if (state == WRITE)
		begin
			fill.opm = OPM_STORE_WORD;
			fill.addr = {missAddr[ADDR_BITS-1:2], 2'b00};	// word aligned
		end
	end

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= IDLE;
			lineValid <= '0;
			dataValid <= 1'b0;
		end
		else
		begin
			dataValid <= 1'b0;
			case (state)
				IDLE, DONE:
				begin
					state <= IDLE;
					if (access && dataWrite)
						state <= WRITE;	// write-through, every store
					else if (access && hit)
						dataValid <= 1'b1;
					else if (access)
						state <= FILL;
				end
				FILL, WRITE:
				begin
					if (portDone)
					begin
						dataValid <= 1'b1;
						state <= DONE;
						if ((state == FILL) && (fill.ok == OK_OK))
							lineValid[missIdx] <= 1'b1;
					end
				end
				default:
					state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (ready && access)
		begin
			missAddr <= dataAddr;
			storeData <= dataWData;
			dataErr <= 1'b0;
			dataRData <= dataWrite ? dataWData : lineWord(lineMem[reqIdx], reqSel);
		end
		if (ready && dataWrite && hit)
			lineMem[reqIdx][reqSel*WORD_BITS +: WORD_BITS] <= dataWData;	// no allocate on miss
		if (portDone)
			dataErr <= (fill.ok == OK_FAULT);
		if (portDone && (state == FILL))
			dataRData <= lineWord(fill.rData, missSel);
		if (portDone && (state == FILL) && (fill.ok == OK_OK))
		begin
			tagMem[missIdx] <= missTag;
			lineMem[missIdx] <= fill.rData;
		end
	end

	// the core waits for each response before the next strobe
	assert property (@(posedge clock) disable iff (!arstN)
		access |-> ready);

endmodule

// ==== hdl/memArbiter.sv ====
`timescale 1ns/1ps

module memArbiter
(
	input logic clock,
	input logic arstN,
	lineFillIf.arbiter icPort,
	lineFillIf.arbiter dcPort,
	output memCachePkg::addrT memAddr,
	output memCachePkg::opmT memOpm,
	output memCachePkg::wordT memWData,
	input memCachePkg::lineT memRData,
	input memCachePkg::okT memOk,
	output logic excValid,
	output memCachePkg::excT excCode,
	output memCachePkg::addrT excAddr
);

	import memCachePkg::*;

	logic icLatch;	// port owned by the fetch side
	logic dcLatch;
	logic icGrant;
	logic dcGrant;
	logic memReady;
	logic faultSeen;

	assign memReady = (memOk == OK_READY);

	// fetch side wins a tie and a held latch keeps the port until opm drops
	assign icGrant = ((icPort.opm != OPM_NONE) || icLatch) &&
		(memReady || icLatch) && !dcLatch;
	assign dcGrant = !icGrant && ((dcPort.opm != OPM_NONE) || dcLatch) &&
		(memReady || dcLatch) && !icLatch;

	assign faultSeen = (memOpm != OPM_NONE) && (memOk == OK_FAULT);

	always_comb
	begin
		memAddr = '0;
		memOpm = OPM_NONE;
		memWData = '0;
		icPort.rData = memRData;
		dcPort.rData = memRData;
		icPort.ok = (icPort.opm != OPM_NONE) ? OK_HOLD : OK_READY;	// waiting side stalls
		dcPort.ok = (dcPort.opm != OPM_NONE) ? OK_HOLD : OK_READY;
		if (icGrant)
		begin
			memAddr = icPort.addr;
			memOpm = icPort.opm;
			memWData = icPort.wData;
			icPort.ok = memOk;
		end
		else if (dcGrant)
		begin
			memAddr = dcPort.addr;
			memOpm = dcPort.opm;
			memWData = dcPort.wData;
			dcPort.ok = memOk;
		end
	end

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			icLatch <= 1'b0;
			dcLatch <= 1'b0;
			excValid <= 1'b0;
		end
		else
		begin
			icLatch <= icGrant && (icPort.opm != OPM_NONE);
			dcLatch <= dcGrant && (dcPort.opm != OPM_NONE);
			excValid <= faultSeen;	// one-cycle report
		end
	end

	always_ff @(posedge clock)
	begin
		if (faultSeen)
		begin
			excCode <= icGrant ? EXC_FETCH_FAULT : EXC_DATA_FAULT;
			excAddr <= memAddr;
		end
	end

	// granted request stays on the external port while memory stalls
	assert property (@(posedge clock) disable iff (!arstN)
		(memOk == OK_HOLD) |=> ($stable(memOpm) && $stable(memAddr)));

endmodule

// ==== hdl/memCacheTop.sv ====
`timescale 1ns/1ps

module memCacheTop
(
	input logic clock,
	input logic arstN,

	input logic fetchReq,
	input memCachePkg::addrT fetchPc,
	output logic fetchValid,
	output memCachePkg::wordT fetchInstr,
	output logic fetchErr,

	input logic dataReq,
	input logic dataWrite,
	input memCachePkg::addrT dataAddr,
	input memCachePkg::wordT dataWData,
	output logic dataValid,
	output logic dataErr,
	output memCachePkg::wordT dataRData,

	output memCachePkg::addrT memAddr,
	output memCachePkg::opmT memOpm,
	output memCachePkg::wordT memWData,
	input memCachePkg::lineT memRData,
	input memCachePkg::okT memOk,

	output logic excValid,
	output memCachePkg::excT excCode,
	output memCachePkg::addrT excAddr
);

	lineFillIf icFill();	// fetch side line fills
	lineFillIf dcFill();	// loads and write-through stores

	instCache uInstCache
	(
		.clock(clock),
		.arstN(arstN),
		.fetchReq(fetchReq),
		.fetchPc(fetchPc),
		.fetchValid(fetchValid),
		.fetchInstr(fetchInstr),
		.fetchErr(fetchErr),
		.fill(icFill)
	);

	dataCache uDataCache
	(
		.clock(clock),
		.arstN(arstN),
		.dataReq(dataReq),
		.dataWrite(dataWrite),
		.dataAddr(dataAddr),
		.dataWData(dataWData),
		.dataValid(dataValid),
		.dataErr(dataErr),
		.dataRData(dataRData),
		.fill(dcFill)
	);

	memArbiter uMemArbiter
	(
		.clock(clock),
		.arstN(arstN),
		.icPort(icFill),
		.dcPort(dcFill),
		.memAddr(memAddr),
		.memOpm(memOpm),
		.memWData(memWData),
		.memRData(memRData),
		.memOk(memOk),
		.excValid(excValid),
		.excCode(excCode),
		.excAddr(excAddr)
	);

endmodule

// ==== verif/extMemModel.sv ====
`timescale 1ns/1ps

module extMemModel
#(
	parameter memCachePkg::addrT FAULT_BASE = 32'h0000_F000
)
(
	input logic clock,
	input logic arstN,
	input memCachePkg::addrT memAddr,
	input memCachePkg::opmT memOpm,
	input memCachePkg::wordT memWData,
	output memCachePkg::lineT memRData,
	output memCachePkg::okT memOk
);

	import memCachePkg::*;

	wordT memWords [addrT];	// only words touched by stores
	int holdLeft;
	logic answerNow;

	function automatic wordT readWord(addrT a);
		if (memWords.exists(a))
			return memWords[a];
		return a ^ 32'hA5A5A5A5;	// untouched memory pattern
	endfunction

	initial
		void'($urandom(89077));

	always @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			memOk <= OK_READY;
			memRData <= '0;
			holdLeft = 0;
		end
		else
		begin
			answerNow = 1'b0;
			if ((memOpm == OPM_NONE) || (memOk == OK_OK) || (memOk == OK_FAULT))
				memOk <= OK_READY;	// requester drops opm after the answer
			else if (memOk == OK_READY)
			begin
				holdLeft = $urandom % 4;	// 0 to 3 wait cycles
				answerNow = (holdLeft == 0);
				memOk <= OK_HOLD;
			end
			else
			begin
				holdLeft = holdLeft - 1;
				answerNow = (holdLeft == 0);
			end

			if (answerNow && (memAddr >= FAULT_BASE))
				memOk <= OK_FAULT;
			else if (answerNow)
			begin
				memOk <= OK_OK;
				if (memOpm == OPM_STORE_WORD)
					memWords[memAddr] = memWData;
				else
					memRData <= {readWord(memAddr + 32'd12), readWord(memAddr + 32'd8),
						readWord(memAddr + 32'd4), readWord(memAddr)};
			end
		end
	end

endmodule

// ==== verif/memCacheTb.sv ====
`timescale 1ns/1ps

module memCacheTb;

	import memCachePkg::*;

	localparam addrT FAULT_BASE = 32'h0000_F000;	// this address and up faults
	localparam int FIELDS = 5;	// op, addr, data, err, hit
	localparam int MAX_OPS = 32;
	localparam int CYCLES_PER_OP = 60;

	logic clock = 1'b0;
	logic arstN;
	logic fetchReq;
	addrT fetchPc;
	logic fetchValid;
	wordT fetchInstr;
	logic fetchErr;
	logic dataReq;
	logic dataWrite;
	addrT dataAddr;
	wordT dataWData;
	logic dataValid;
	logic dataErr;
	wordT dataRData;
	addrT memAddr;
	opmT memOpm;
	wordT memWData;
	lineT memRData;
	okT memOk;
	logic excValid;
	excT excCode;
	addrT excAddr;

	logic [31:0] stim [FIELDS*MAX_OPS];
	wordT shadow [addrT];	// words written by stores so far
	int errorCount;
	int opCount;
	int cycleCount = 0;
	int cycleLimit;

	// responses collected during one operation
	int fetchSeen;
	int dataSeen;
	int excSeen;
	int fetchAt;
	int dataAt;
	wordT gotInstr;
	wordT gotData;
	logic gotFetchErr;
	logic gotDataErr;
	excT gotExcCode;
	addrT gotExcAddr;

	memCacheTop u_dut (.*);

	extMemModel #(.FAULT_BASE(FAULT_BASE)) memModel (.*);

	always #4 clock = ~clock;

	always @(posedge clock)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit)
		begin
			$display("timeout: run did not finish within %0d cycles, errors: %0d",
				cycleLimit, errorCount);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// memory contents the DUT should return for a byte address
	function automatic wordT expectWord(addrT a);
		addrT wordAddr;
		wordAddr = {a[31:2], 2'b00};
		if (shadow.exists(wordAddr))
			return shadow[wordAddr];
		return wordAddr ^ 32'hA5A5A5A5;
	endfunction

	task automatic checkValue(string name, string what, logic [31:0] expected,
		logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			$display("FAILED %s %s: expected %h actual %h", name, what, expected, actual);
			errorCount++;
		end
	endtask

	task automatic verifyLatency(string name, string side, logic expHit, int at);
		if (expHit)
		begin
			assert (at == 1)
			else
			begin
				$display("FAILED %s %s latency: expected 1 actual %0d", name, side, at);
				errorCount++;
			end
		end
		else
		begin
			assert (at > 1)	// a miss or store must go to memory
			else
			begin
				$display("FAILED %s %s latency: expected more than 1 actual %0d",
					name, side, at);
				errorCount++;
			end
		end
	endtask

	task automatic sampleOutputs(int cycle);
		if (fetchValid)
		begin
			fetchSeen++;
			fetchAt = cycle;
			gotInstr = fetchInstr;
			gotFetchErr = fetchErr;
		end
		if (dataValid)
		begin
			dataSeen++;
			dataAt = cycle;
			gotData = dataRData;
			gotDataErr = dataErr;
		end
		if (excValid)
		begin
			excSeen++;
			gotExcCode = excCode;
			gotExcAddr = excAddr;
		end
	endtask

	task automatic runOperation(int idx);
		logic [31:0] op;
		addrT addr;
		wordT data;
		logic expErr;
		logic expHit;
		addrT loadAddr;
		logic wantFetch;
		logic wantData;
		int cycle;
		string name;
		op = stim[idx*FIELDS];
		addr = stim[idx*FIELDS+1];
		data = stim[idx*FIELDS+2];
		expErr = stim[idx*FIELDS+3][0];
		expHit = stim[idx*FIELDS+4][0];
		loadAddr = (op == 4) ? data : addr;	// paired load takes the data column
		wantFetch = (op == 1) || (op == 4);
		wantData = (op != 1);
		case (op)
			1: name = $sformatf("op%0d_fetch_%h", idx, addr);
			2: name = $sformatf("op%0d_load_%h", idx, addr);
			3: name = $sformatf("op%0d_store_%h", idx, addr);
			4: name = $sformatf("op%0d_fetch_%h_load_%h", idx, addr, loadAddr);
			default:
			begin
				name = $sformatf("op%0d_unknown", idx);
				$display("operation %0d has an unknown code %0d", idx, op);
				errorCount++;
			end
		endcase
		fetchSeen = 0;
		dataSeen = 0;
		excSeen = 0;
		fetchAt = 0;
		dataAt = 0;

		@(negedge clock);
		fetchReq = wantFetch;
		fetchPc = addr;
		dataReq = (op == 2) || (op == 4);
		dataWrite = (op == 3);
		dataAddr = loadAddr;
		dataWData = data;
		cycle = 0;
		while ((wantFetch && (fetchSeen == 0)) || (wantData && (dataSeen == 0)))
		begin
			@(negedge clock);
			fetchReq = 1'b0;
			dataReq = 1'b0;
			dataWrite = 1'b0;
			cycle++;
			sampleOutputs(cycle);
		end
		repeat (2)	// catch late or doubled strobes
		begin
			@(negedge clock);
			cycle++;
			sampleOutputs(cycle);
		end

		checkValue(name, "fetch responses", wantFetch ? 1 : 0, fetchSeen);
		checkValue(name, "data responses", wantData ? 1 : 0, dataSeen);
		if (wantFetch)
		begin
			checkValue(name, "fetchErr", 32'(expErr), 32'(gotFetchErr));
			if (!expErr)
				checkValue(name, "fetchInstr", expectWord(addr), gotInstr);
			verifyLatency(name, "fetch", expHit, fetchAt);
		end
		if (wantData)
		begin
			checkValue(name, "dataErr", 32'(expErr), 32'(gotDataErr));
			if (!expErr && (op != 3))
				checkValue(name, "dataRData", expectWord(loadAddr), gotData);
			verifyLatency(name, "data", expHit, dataAt);
		end
		checkValue(name, "exception reports", 32'(expErr), excSeen);
		if (expErr && (excSeen == 1))
		begin
			checkValue(name, "excCode",
				wantFetch ? 32'(EXC_FETCH_FAULT) : 32'(EXC_DATA_FAULT), 32'(gotExcCode));
			checkValue(name, "excAddr",
				(op == 3) ? {addr[31:2], 2'b00} : {addr[31:4], 4'h0}, gotExcAddr);
		end
		if ((op == 3) && (addr < FAULT_BASE))
			shadow[{addr[31:2], 2'b00}] = data;	// write-through reaches memory
	endtask

	initial
	begin
		arstN = 1'b0;
		fetchReq = 1'b0;
		fetchPc = '0;
		dataReq = 1'b0;
		dataWrite = 1'b0;
		dataAddr = '0;
		dataWData = '0;
		errorCount = 0;
		for (int i = 0; i < FIELDS*MAX_OPS; i++)
			stim[i] = '0;
		$readmemh("verif/stimulusInput.txt", stim);
		opCount = 0;
		while ((opCount < MAX_OPS) && (stim[opCount*FIELDS] != 0))
			opCount++;
		cycleLimit = CYCLES_PER_OP * (opCount + 1);	// one extra slot for reset
		if (opCount == 0)
		begin
			$display("no operations were read from verif/stimulusInput.txt");
			errorCount++;
		end

		repeat (8) @(negedge clock);
		arstN = 1'b1;
		@(negedge clock);
		// quiet port before the first strobe
		checkValue("reset", "memOpm", 32'(OPM_NONE), 32'(memOpm));
		checkValue("reset", "fetchValid", 0, 32'(fetchValid));
		checkValue("reset", "dataValid", 0, 32'(dataValid));
		checkValue("reset", "excValid", 0, 32'(excValid));

		for (int i = 0; i < opCount; i++)
			runOperation(i);

		$display("operations: %0d, errors: %0d", opCount, errorCount);
		if (errorCount == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== verif/stimulusInput.txt ====
// op addr data err hit, hex; op 1 fetch, 2 load, 3 store, 4 fetch at addr plus load at data
// err 1 expects a bus fault with one exception report, hit 1 expects a one-cycle answer
1 00000040 00000000 0 0
1 00000040 00000000 0 1
1 00000048 00000000 0 1
2 00000100 00000000 0 0
3 00000104 deadbeef 0 0
2 00000104 00000000 0 1
2 00000200 00000000 0 0
2 00000104 00000000 0 0
3 00000300 12345678 0 0
2 00000300 00000000 0 0
4 00000080 00000500 0 0
4 00000084 00000504 0 1
1 0000f010 00000000 1 0
1 0000f010 00000000 1 0
2 0000f024 00000000 1 0
2 0000f024 00000000 1 0
3 0000f038 cafef00d 1 0

// ==== verilog.f ====
hdl/memCachePkg.sv
hdl/lineFillIf.sv
hdl/instCache.sv
hdl/dataCache.sv
hdl/memArbiter.sv
hdl/memCacheTop.sv
verif/extMemModel.sv
verif/memCacheTb.sv

// ==== Makefile ====
# Verilator flow for the level-one memory subsystem testbench

VERILATOR ?= verilator
TOP ?= memCacheTb
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build $(TOP) with Verilator, run it, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "test failed, no result in $(LOG)"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
